//--- verilog/conv_pkg.sv
`default_nettype none

package conv_pkg;

	localparam int PIX_W      = 8;                   // pixel and weight width
	localparam int ROW_PIX    = 8;                   // pixels per row, also window count
	localparam int ROW_W      = ROW_PIX * PIX_W;     // one packed image row
	localparam int KER_DIM    = 3;                   // kernel side
	localparam int KER_TAPS   = KER_DIM * KER_DIM;   // 3x3 taps
	localparam int PROD_W     = 2 * PIX_W;           // full 8x8 unsigned product
	localparam int LANE_W     = KER_TAPS * PROD_W;   // nine products of one window
	localparam int RES_W      = ROW_PIX * LANE_W;    // all eight windows
	localparam int WBEAT_W    = 64;                  // weight bus width
	localparam int KER_BEATS  = 2;                   // beats per kernel
	localparam int BEAT_CNT_W = 2;                   // beat counter holds 0..2

	typedef logic [PIX_W-1:0]          pixel_t;      // pixel or weight
	typedef logic [ROW_W-1:0]          row_t;        // pixel p at bits 8p+
	typedef logic [KER_TAPS*PIX_W-1:0] kernel_t;     // weight k at bits 8k+
	typedef logic [LANE_W-1:0]         lane_res_t;   // product k at bits 16k+

	// command level on i_ctrl
	typedef enum logic [1:0] {
		CMD_END   = 2'd0,
		CMD_START = 2'd1,
		CMD_HOLD  = 2'd2
	} cmd_e;

	typedef enum logic [1:0] {
		ST_FINISH  = 2'd1,                           // sticky until reset
		ST_WAIT    = 2'd2,                           // rows and weights load here
		ST_COMPUTE = 2'd3                            // products flow every cycle
	} state_e;

endpackage

`default_nettype wire

//--- verilog/operand_if.sv
`timescale 1ns/1ns
`default_nettype none

interface operand_if;

	conv_pkg::row_t    row_old;     // oldest row, kernel row 0
	conv_pkg::row_t    row_mid;     // kernel row 1
	conv_pkg::row_t    row_new;     // newest row, kernel row 2
	conv_pkg::kernel_t kernel;      // nine weights

	modport rows_src (
		output row_old,
		output row_mid,
		output row_new
	);

	modport ker_src (
		output kernel
	);

	// window multipliers only read
	modport sink (
		input row_old,
		input row_mid,
		input row_new,
		input kernel
	);

endinterface

`default_nettype wire

//--- verilog/conv_ctrl.sv
`timescale 1ns/1ns
`default_nettype none

module conv_ctrl (
	input  wire                 clk,
	input  wire                 rst,          // active low, async
	input  wire conv_pkg::cmd_e i_ctrl,       // start/hold/end level
	output logic                o_wait,       // buffers may load
	output logic                o_hold,       // one cycle on compute -> wait
	output logic                o_res_valid,  // products on o_result are current
	output logic                o_finish      // end reached
);

	conv_pkg::state_e state;
	conv_pkg::state_e state_nxt;

	always_comb begin
		state_nxt = state;                                  // stay by default
		case (state)
			conv_pkg::ST_WAIT: begin
				if (i_ctrl == conv_pkg::CMD_START) begin
					state_nxt = conv_pkg::ST_COMPUTE;
				end else if (i_ctrl == conv_pkg::CMD_END) begin
					state_nxt = conv_pkg::ST_FINISH;
				end
			end
			conv_pkg::ST_COMPUTE: begin
				if (i_ctrl == conv_pkg::CMD_HOLD) begin
					state_nxt = conv_pkg::ST_WAIT;          // back to loading
				end else if (i_ctrl == conv_pkg::CMD_END) begin
					state_nxt = conv_pkg::ST_FINISH;
				end
			end
			conv_pkg::ST_FINISH: state_nxt = conv_pkg::ST_FINISH;  // only reset leaves
			default: state_nxt = conv_pkg::ST_WAIT;         // recover from bad encoding
		endcase
	end

	always_ff @(posedge clk or negedge rst) begin
		if (!rst) begin
			state       <= conv_pkg::ST_WAIT;
			o_res_valid <= 1'b0;
		end else begin
			state       <= state_nxt;
			o_res_valid <= (state == conv_pkg::ST_COMPUTE);  // multipliers lag one cycle
		end
	end

	assign o_wait   = (state == conv_pkg::ST_WAIT);
	assign o_finish = (state == conv_pkg::ST_FINISH);
	assign o_hold   = (state == conv_pkg::ST_COMPUTE) && (i_ctrl == conv_pkg::CMD_HOLD);

	// state register only ever holds one of the three encodings
	a_state_legal: assert property (@(posedge clk) disable iff (!rst)
		state inside {conv_pkg::ST_FINISH, conv_pkg::ST_WAIT, conv_pkg::ST_COMPUTE})
		else $error("conv_ctrl: illegal state %0d", state);

	// a valid run only opens after a start taken in wait, so never out of finish
	a_no_valid_after_finish: assert property (@(posedge clk) disable iff (!rst)
		$rose(o_res_valid) |-> ($past(state, 2) == conv_pkg::ST_WAIT)
			&& ($past(i_ctrl, 2) == conv_pkg::CMD_START))
		else $error("conv_ctrl: result valid rose out of finish");

endmodule

`default_nettype wire

//--- verilog/row_buffer.sv
`timescale 1ns/1ns
`default_nettype none

module row_buffer (
	input  wire                 clk,
	input  wire                 rst,        // active low, async
	input  wire                 i_wait,     // controller in wait
	input  wire                 i_valid,    // row strobe
	input  wire conv_pkg::row_t i_data,     // eight packed pixels
	operand_if.rows_src         ops         // three rows out to the windows
);

	conv_pkg::row_t row_old_q;
	conv_pkg::row_t row_mid_q;
	conv_pkg::row_t row_new_q;
	logic           row_take;

	// rows only accepted while waiting
	assign row_take = i_wait && i_valid;

	// vertical sliding window, oldest row drops out
	always_ff @(posedge clk or negedge rst) begin
		if (!rst) begin
			row_old_q <= '0;
			row_mid_q <= '0;
			row_new_q <= '0;
		end else if (row_take) begin
			row_old_q <= row_mid_q;   // mid ages to old
			row_mid_q <= row_new_q;   // new ages to mid
			row_new_q <= i_data;      // incoming row
		end
	end

	assign ops.row_old = row_old_q;
	assign ops.row_mid = row_mid_q;
	assign ops.row_new = row_new_q;

endmodule

`default_nettype wire

//--- verilog/weight_buffer.sv
`timescale 1ns/1ns
`default_nettype none

module weight_buffer (
	input  wire                                clk,
	input  wire                                rst,        // active low, async
	input  wire                                i_wait,     // controller in wait
	input  wire                                i_hold,     // compute -> wait, rearm loader
	input  wire                                i_valid,    // row strobe wins the cycle
	input  wire                                i_w_valid,  // weight beat strobe
	input  wire [conv_pkg::WBEAT_W-1:0]        i_w_data,   // one weight beat
	operand_if.ker_src                         ops         // kernel out to the windows
);

	conv_pkg::kernel_t                 kernel_q;
	logic [conv_pkg::BEAT_CNT_W-1:0]   beat_cnt;    // beats taken so far
	logic                              beat_full;
	logic                              beat_take;

	assign beat_full = (int'(beat_cnt) >= conv_pkg::KER_BEATS);   // kernel complete
	assign beat_take = i_wait && !i_valid && i_w_valid && !beat_full;

	always_ff @(posedge clk or negedge rst) begin
		if (!rst) begin
			kernel_q <= '0;
		end else if (beat_take) begin
			case (beat_cnt)
				2'd0: kernel_q[conv_pkg::WBEAT_W-1:0] <= i_w_data;   // weights 0..7
				2'd1: kernel_q[conv_pkg::KER_TAPS*conv_pkg::PIX_W-1 -: conv_pkg::PIX_W]
					<= i_w_data[conv_pkg::PIX_W-1:0];                // weight 8 from low byte
				default: kernel_q <= kernel_q;
			endcase
		end
	end

	// saturates at two, cleared on hold
	always_ff @(posedge clk or negedge rst) begin
		if (!rst) begin
			beat_cnt <= '0;
		end else if (i_hold) begin
			beat_cnt <= '0;
		end else if (beat_take) begin
			beat_cnt <= beat_cnt + 1'b1;
		end
	end

	assign ops.kernel = kernel_q;

	a_beat_cnt_range: assert property (@(posedge clk) disable iff (!rst)
		int'(beat_cnt) <= conv_pkg::KER_BEATS)
		else $error("weight_buffer: beat counter overran %0d", beat_cnt);

endmodule

`default_nettype wire

//--- verilog/window_mult.sv
`timescale 1ns/1ns
`default_nettype none

module window_mult #(
	parameter int COL = 0                          // first pixel column of the window
) (
	input  wire                      clk,
	input  wire                      rst,          // active low, async
	operand_if.sink                  ops,          // rows and kernel
	output wire conv_pkg::lane_res_t o_lane        // nine raw products
);

	conv_pkg::row_t    rows_q [conv_pkg::KER_DIM];  // 0 old, 1 mid, 2 new
	conv_pkg::kernel_t ker_q;

	// operand stage, taken every clock
	always_ff @(posedge clk or negedge rst) begin
		if (!rst) begin
			rows_q[0] <= '0;
			rows_q[1] <= '0;
			rows_q[2] <= '0;
			ker_q     <= '0;
		end else begin
			rows_q[0] <= ops.row_old;
			rows_q[1] <= ops.row_mid;
			rows_q[2] <= ops.row_new;
			ker_q     <= ops.kernel;
		end
	end

	for (genvar k = 0; k < conv_pkg::KER_TAPS; k++) begin : g_tap
		localparam int ROW_SEL = k / conv_pkg::KER_DIM;                               // kernel row
		localparam int PIX_SEL = (COL + k % conv_pkg::KER_DIM) % conv_pkg::ROW_PIX;   // wraps past 7

		conv_pkg::pixel_t              pix;
		conv_pkg::pixel_t              wgt;
		logic [conv_pkg::PROD_W-1:0]   pix_ext;
		logic [conv_pkg::PROD_W-1:0]   wgt_ext;

		assign pix     = rows_q[ROW_SEL][PIX_SEL*conv_pkg::PIX_W +: conv_pkg::PIX_W];
		assign wgt     = ker_q[k*conv_pkg::PIX_W +: conv_pkg::PIX_W];
		assign pix_ext = {{(conv_pkg::PROD_W - conv_pkg::PIX_W){1'b0}}, pix};   // unsigned
		assign wgt_ext = {{(conv_pkg::PROD_W - conv_pkg::PIX_W){1'b0}}, wgt};

		assign o_lane[k*conv_pkg::PROD_W +: conv_pkg::PROD_W] = pix_ext * wgt_ext;
	end

endmodule

`default_nettype wire

//--- verilog/conv_top.sv
`timescale 1ns/1ns
`default_nettype none

module conv_top (
	input  wire                          clk,
	input  wire                          rst,          // active low, async
	input  wire conv_pkg::cmd_e          i_ctrl,       // start/hold/end
	input  wire conv_pkg::row_t          i_data,       // image row
	input  wire                          i_valid,      // row strobe
	input  wire [conv_pkg::WBEAT_W-1:0]  i_w_data,     // weight beat
	input  wire                          i_w_valid,    // weight strobe
	output wire [conv_pkg::RES_W-1:0]    o_result,     // eight lanes of nine products
	output wire                          o_res_valid,  // result valid
	output wire                          o_finish      // end reached
);

	wire ctrl_wait;   // loading window
	wire ctrl_hold;   // rearm kernel loader

	operand_if ops ();

	conv_ctrl u_ctrl (
		.clk         (clk),
		.rst         (rst),
		.i_ctrl      (i_ctrl),
		.o_wait      (ctrl_wait),
		.o_hold      (ctrl_hold),
		.o_res_valid (o_res_valid),
		.o_finish    (o_finish)
	);

	row_buffer u_rows (
		.clk     (clk),
		.rst     (rst),
		.i_wait  (ctrl_wait),
		.i_valid (i_valid),
		.i_data  (i_data),
		.ops     (ops)
	);

	// row strobe also feeds here so rows win over weights
	weight_buffer u_weights (
		.clk       (clk),
		.rst       (rst),
		.i_wait    (ctrl_wait),
		.i_hold    (ctrl_hold),
		.i_valid   (i_valid),
		.i_w_valid (i_w_valid),
		.i_w_data  (i_w_data),
		.ops       (ops)
	);

	// one window per pixel column, lanes 6 and 7 wrap to columns 0 and 1
	for (genvar c = 0; c < conv_pkg::ROW_PIX; c++) begin : g_win
		window_mult #(
			.COL (c)
		) u_win (
			.clk    (clk),
			.rst    (rst),
			.ops    (ops),
			.o_lane (o_result[c*conv_pkg::LANE_W +: conv_pkg::LANE_W])
		);
	end

endmodule

`default_nettype wire

//--- verification/tb_clock.sv
`timescale 1ns/1ns
`default_nettype none

module tb_clock #(
	parameter int PERIOD = 100                 // ns per cycle
) (
	output logic clk
);

	initial begin
		clk = 1'b0;                            // low at time zero
	end

	// half period each phase
	always begin
		#(PERIOD / 2) clk = ~clk;
	end

endmodule

`default_nettype wire

//--- include/conv_model.svh
`ifndef CONV_MODEL_SVH
`define CONV_MODEL_SVH

conv_pkg::row_t             m_rows [3];    // 0 old, 1 mid, 2 new
conv_pkg::kernel_t          m_kernel;      // weight k at bits 8k+
int                         m_beats;       // kernel beats taken since clear
conv_pkg::state_e           m_state;       // controller state
logic [conv_pkg::RES_W-1:0] exp_result;    // outputs expected after the next edge
logic                       exp_valid;
logic                       exp_finish;

// nine products of window c from the current row store and kernel
function automatic conv_pkg::lane_res_t model_lane(input int c);
	conv_pkg::lane_res_t         lane;
	logic [conv_pkg::PROD_W-1:0] pix;
	logic [conv_pkg::PROD_W-1:0] wgt;
	int                          row;
	int                          col;
	lane = '0;
	for (int k = 0; k < conv_pkg::KER_TAPS; k++) begin
		row = k / 3;                                  // tap row, 0 is oldest
		col = (c + k % 3) % conv_pkg::ROW_PIX;        // lanes 6, 7 reach columns 0, 1
		pix = {8'h00, m_rows[row][col*conv_pkg::PIX_W +: conv_pkg::PIX_W]};
		wgt = {8'h00, m_kernel[k*conv_pkg::PIX_W +: conv_pkg::PIX_W]};
		lane[k*conv_pkg::PROD_W +: conv_pkg::PROD_W] = pix * wgt;   // unsigned
	end
	return lane;
endfunction

function automatic void model_reset();
	m_rows[0]  = '0;
	m_rows[1]  = '0;
	m_rows[2]  = '0;
	m_kernel   = '0;
	m_beats    = 0;
	m_state    = conv_pkg::ST_WAIT;
	exp_result = '0;
	exp_valid  = 1'b0;
	exp_finish = 1'b0;
endfunction

// one clock edge with the given inputs present
function automatic void model_advance(input conv_pkg::cmd_e ctrl, input logic valid,
	input conv_pkg::row_t data, input logic wvalid,
	input logic [conv_pkg::WBEAT_W-1:0] wdata);
	for (int c = 0; c < conv_pkg::ROW_PIX; c++) begin
		exp_result[c*conv_pkg::LANE_W +: conv_pkg::LANE_W] = model_lane(c);  // operands before edge
	end
	exp_valid = (m_state == conv_pkg::ST_COMPUTE);
	if (m_state == conv_pkg::ST_WAIT) begin
		if (valid) begin                              // row wins the cycle
			m_rows[0] = m_rows[1];
			m_rows[1] = m_rows[2];
			m_rows[2] = data;
		end else if (wvalid && m_beats < 2) begin     // third beat dropped
			if (m_beats == 0) begin
				m_kernel[8*conv_pkg::PIX_W-1:0] = wdata;                    // weights 0..7
			end else begin
				m_kernel[8*conv_pkg::PIX_W +: conv_pkg::PIX_W] = wdata[7:0];  // weight 8
			end
			m_beats++;
		end
	end
	case (m_state)
		conv_pkg::ST_WAIT: begin
			if (ctrl == conv_pkg::CMD_START) begin
				m_state = conv_pkg::ST_COMPUTE;
			end else if (ctrl == conv_pkg::CMD_END) begin
				m_state = conv_pkg::ST_FINISH;
			end
		end
		conv_pkg::ST_COMPUTE: begin
			if (ctrl == conv_pkg::CMD_HOLD) begin
				m_beats = 0;                          // loader rearmed
				m_state = conv_pkg::ST_WAIT;
			end else if (ctrl == conv_pkg::CMD_END) begin
				m_state = conv_pkg::ST_FINISH;
			end
		end
		default: m_state = m_state;                   // finish is sticky
	endcase
	exp_finish = (m_state == conv_pkg::ST_FINISH);
endfunction

`endif

//--- verification/conv_tb.sv
`timescale 1ns/1ns
`default_nettype none

module conv_tb;

	localparam int CLK_PERIOD  = 100;        // ns
	localparam int RST_CYCLES  = 10;
	localparam int LOAD_STEPS  = 5;          // three rows, two beats
	localparam int N_IDLE      = 8;
	localparam int N_RUN       = 12;         // compute cycles per run
	localparam int N_MIX       = 20;         // random strobe cycles
	localparam int N_AFTER     = 8;          // random commands after end
	localparam int TEST_CYCLES = 2 * (RST_CYCLES + 1) + N_IDLE + 3 * LOAD_STEPS
		+ 3 * N_RUN + 2 * N_MIX + 2 * N_AFTER + 16;

	logic                         clk;
	logic                         rst;
	conv_pkg::cmd_e               i_ctrl;
	conv_pkg::row_t               i_data;
	logic                         i_valid;
	logic [conv_pkg::WBEAT_W-1:0] i_w_data;
	logic                         i_w_valid;
	logic [conv_pkg::RES_W-1:0]   o_result;
	logic                         o_res_valid;
	logic                         o_finish;

	string cur_test;
	int    n_checks;
	int    n_errors;
	int    test_errors;

	`include "conv_model.svh"

	tb_clock #(.PERIOD(CLK_PERIOD)) u_clock (.clk(clk));

	conv_top uut (
		.clk         (clk),
		.rst         (rst),
		.i_ctrl      (i_ctrl),
		.i_data      (i_data),
		.i_valid     (i_valid),
		.i_w_data    (i_w_data),
		.i_w_valid   (i_w_valid),
		.o_result    (o_result),
		.o_res_valid (o_res_valid),
		.o_finish    (o_finish)
	);

	function automatic logic rand_bit();
		return ($urandom_range(0, 1) == 1);
	endfunction

	function automatic conv_pkg::row_t rand_row();
		return {$urandom(), $urandom()};        // 64 random bits
	endfunction

	function automatic conv_pkg::cmd_e rand_cmd();
		case ($urandom_range(0, 2))
			0: return conv_pkg::CMD_END;
			1: return conv_pkg::CMD_START;
			default: return conv_pkg::CMD_HOLD;
		endcase
	endfunction

	task automatic check_result(input string name, input conv_pkg::lane_res_t exp,
		input conv_pkg::lane_res_t act);
		n_checks++;
		if (act !== exp) begin
			n_errors++;
			test_errors++;
			$display("Fail %s: expected %h, actual %h", name, exp, act);
		end
	endtask

	task automatic check_flag(input string name, input logic exp, input logic act);
		n_checks++;
		if (act !== exp) begin
			n_errors++;
			test_errors++;
			$display("Fail %s: expected %b, actual %b", name, exp, act);
		end
	endtask

	task automatic compare_outputs();
		for (int c = 0; c < conv_pkg::ROW_PIX; c++) begin   // wrap lanes included
			check_result($sformatf("%s lane %0d", cur_test, c),
				exp_result[c*conv_pkg::LANE_W +: conv_pkg::LANE_W],
				o_result[c*conv_pkg::LANE_W +: conv_pkg::LANE_W]);
		end
		check_flag({cur_test, " res_valid"}, exp_valid, o_res_valid);
		check_flag({cur_test, " finish"}, exp_finish, o_finish);
	endtask

	// drive for the next edge, check what the last edge produced
	task automatic step(input conv_pkg::cmd_e ctrl, input logic valid,
		input conv_pkg::row_t data, input logic wvalid,
		input logic [conv_pkg::WBEAT_W-1:0] wdata);
		@(posedge clk);
		i_ctrl    <= ctrl;
		i_valid   <= valid;
		i_data    <= data;
		i_w_valid <= wvalid;
		i_w_data  <= wdata;
		@(negedge clk);                          // outputs settled
		compare_outputs();
		model_advance(ctrl, valid, data, wvalid, wdata);
	endtask

	task automatic do_reset();
		@(posedge clk);
		rst       <= 1'b0;
		i_ctrl    <= conv_pkg::CMD_HOLD;         // no effect in wait
		i_valid   <= 1'b0;
		i_data    <= '0;
		i_w_valid <= 1'b0;
		i_w_data  <= '0;
		repeat (RST_CYCLES) @(posedge clk);
		rst <= 1'b1;
		model_reset();
		@(negedge clk);                          // reset values before the first live edge
		compare_outputs();
		model_advance(conv_pkg::CMD_HOLD, 1'b0, '0, 1'b0, '0);   // first live edge
	endtask

	task automatic idle_steps(input int n);
		repeat (n) step(conv_pkg::CMD_HOLD, 1'b0, '0, 1'b0, '0);
	endtask

	task automatic compute_steps(input int n);
		repeat (n) step(conv_pkg::CMD_START, 1'b0, '0, 1'b0, '0);   // start keeps compute
	endtask

	// three rows then a two-beat kernel, all in wait
	task automatic load_image();
		repeat (3) step(conv_pkg::CMD_HOLD, 1'b1, rand_row(), 1'b0, '0);
		repeat (2) step(conv_pkg::CMD_HOLD, 1'b0, '0, 1'b1, rand_row());
	endtask

	task automatic random_steps(input int n, input bit any_cmd, input conv_pkg::cmd_e ctrl);
		conv_pkg::cmd_e cmd;
		repeat (n) begin
			cmd = any_cmd ? rand_cmd() : ctrl;
			step(cmd, rand_bit(), rand_row(), rand_bit(), rand_row());
		end
	endtask

	task automatic open_test(input string name);
		cur_test    = name;
		test_errors = 0;
	endtask

	task automatic close_test();
		if (test_errors == 0) begin
			$display("%s: ok", cur_test);
		end else begin
			$display("%s: %0d mismatches", cur_test, test_errors);
		end
	endtask

	initial begin
		#((TEST_CYCLES + 100) * CLK_PERIOD);
		$display("watchdog: simulation ran past its cycle budget and was stopped");
		$display("TESTS FAILED");
		$finish;
	end

	initial begin
		rst       = 1'b0;
		i_ctrl    = conv_pkg::CMD_HOLD;
		i_data    = '0;
		i_valid   = 1'b0;
		i_w_data  = '0;
		i_w_valid = 1'b0;
		n_checks  = 0;
		n_errors  = 0;
		void'($urandom(75));                     // fixed seed
		model_reset();

		open_test("reset");
		do_reset();
		idle_steps(N_IDLE);
		close_test();

		open_test("random_compute");
		load_image();
		compute_steps(N_RUN);
		idle_steps(2);                           // hold back to wait
		close_test();

		open_test("priority");
		random_steps(N_MIX, 1'b0, conv_pkg::CMD_HOLD);   // strobes together and apart
		compute_steps(N_RUN);
		idle_steps(1);
		close_test();

		open_test("hold_reload");
		load_image();                            // fresh kernel after hold
		compute_steps(N_RUN);
		idle_steps(3);                           // valid drops a cycle after hold
		close_test();

		open_test("ignored_inputs");
		compute_steps(2);
		random_steps(N_MIX, 1'b0, conv_pkg::CMD_START);  // loads during compute
		idle_steps(1);
		close_test();

		open_test("end");
		step(conv_pkg::CMD_END, 1'b0, '0, 1'b0, '0);     // end from wait
		random_steps(N_AFTER, 1'b1, conv_pkg::CMD_HOLD);
		do_reset();
		load_image();
		compute_steps(4);
		step(conv_pkg::CMD_END, 1'b0, '0, 1'b0, '0);     // end from compute
		random_steps(N_AFTER, 1'b1, conv_pkg::CMD_HOLD);
		@(posedge clk);                          // last edge still owed a check
		@(negedge clk);
		compare_outputs();
		close_test();

		$display("checks %0d, errors %0d", n_checks, n_errors);
		if (n_errors == 0) begin
			$display("TESTS PASSED");
		end else begin
			$display("TESTS FAILED");
		end
		$finish;
	end

endmodule

`default_nettype wire

//--- conv_engine.f
+incdir+include
verilog/conv_pkg.sv
verilog/operand_if.sv
verilog/conv_ctrl.sv
verilog/row_buffer.sv
verilog/weight_buffer.sv
verilog/window_mult.sv
verilog/conv_top.sv
verification/tb_clock.sv
verification/conv_tb.sv

//--- run.sh
#!/bin/sh
# Build and run the convolution front end testbench with Verilator.
set -e

cd "$(dirname "$0")"

LOG=sim.log
BIN=conv_sim

rm -rf obj_dir
rm -f "$LOG"

verilator --binary --timing --assert \
	--top-module conv_tb \
	-f conv_engine.f \
	-o "$BIN"

status=0
./obj_dir/"$BIN" > "$LOG" 2>&1 || status=$?
cat "$LOG"

if [ "$status" -ne 0 ]; then
	echo "simulator exited with status $status"
	exit 1
fi

if grep -q "TESTS FAILED" "$LOG"; then
	echo "simulation reported failure, see $LOG"
	exit 1
fi

echo "simulation log clean"
exit 0
